//--- logic/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int SETS    = 64;
    localparam int INDEX_W = 6;
    localparam int TAG_W   = 23;
    localparam int WORD_W  = 32;

    // one ram row carries both ways, way 0 in the low half
    localparam int LINE_W  = 128;

    // register port
    localparam int CFG_ADDR_W = 2;

    localparam logic [CFG_ADDR_W-1:0] CFG_CTRL   = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] CFG_HITS   = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] CFG_MISSES = 2'd2;

    // fetch address split into its cache fields
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic               word;
        logic [1:0]         offset;
    } fetch_fields_t;

    // the same fetch word, seen raw or by field
    typedef union packed {
        logic [WORD_W-1:0] raw;
        fetch_fields_t     fields;
    } fetch_addr_u;

    // lookup result
    typedef struct packed {
        logic hit;
        logic way;
    } hit_info_t;

    // tag store fill
    typedef struct packed {
        logic               we;
        logic               way;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
    } tag_wr_t;

    // steering from the register block
    typedef struct packed {
        logic enable;
        logic flush;
    } cfg_t;

    // event pulses, one per finished lookup
    typedef struct packed {
        logic hit;
        logic miss;
    } stat_t;

endpackage

`default_nettype wire

//--- logic/icache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store import icache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic [INDEX_W-1:0] lookup_index,
    input  logic [TAG_W-1:0]   lookup_tag,
    input  tag_wr_t            tag_wr,
    input  logic               touch,
    output hit_info_t          hit,
    output logic               victim
);

    logic [TAG_W-1:0] tag_mem [2][SETS];

    // valid bits addressed as {way, index}
    logic [2*SETS-1:0] valid_q;

    // per-set victim pointer
    logic [SETS-1:0] lru_q;

    logic [1:0] way_valid;
    logic [1:0] way_hit;

    assign way_valid[0] = valid_q[{1'b0, lookup_index}];
    assign way_valid[1] = valid_q[{1'b1, lookup_index}];

    assign way_hit[0] = way_valid[0] && (tag_mem[0][lookup_index] == lookup_tag);
    assign way_hit[1] = way_valid[1] && (tag_mem[1][lookup_index] == lookup_tag);

    assign hit.hit = way_hit[0] | way_hit[1];
    assign hit.way = way_hit[1];

    // empty way first, way 0 before way 1
    always_comb begin
        if (!way_valid[0]) begin
            victim = 1'b0;
        end else if (!way_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[lookup_index];
        end
    end

    always_ff @(posedge clk) begin
        if (tag_wr.we) begin
            tag_mem[tag_wr.way][tag_wr.index] <= tag_wr.tag;
        end
    end

    // flush wipes the whole array in one cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
        end else if (tag_wr.we) begin
            valid_q[{tag_wr.way, tag_wr.index}] <= 1'b1;
        end
    end

    // point away from the way just used
    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (tag_wr.we) begin
            lru_q[tag_wr.index] <= ~tag_wr.way;
        end else if (touch) begin
            lru_q[lookup_index] <= ~hit.way;
        end
    end

    // a fill only ever targets the victim, so a tag lives in one way
    a_one_way_hit: assert property (
        @(posedge clk) disable iff (rst)
        !(way_hit[0] && way_hit[1])
    );

endmodule

`default_nettype wire

//--- logic/icache_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram import icache_pkg::*; (
    input  logic                clk,
    input  logic [INDEX_W-1:0]  rd_index,
    input  logic                rd_en,
    input  logic [INDEX_W-1:0]  wr_index,
    input  logic                wr_way,
    input  logic                wr_en,
    input  logic [LINE_W/2-1:0] wr_line,
    output logic [LINE_W-1:0]   rd_line
);

    // behavioral model of the single-port line macro
    logic [LINE_W-1:0] mem [SETS];

    // only the chosen way's half is written
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index][wr_way*(LINE_W/2) +: LINE_W/2] <= wr_line;
        end
    end

    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_line <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // fetch side
    input  logic                valid,
    input  fetch_addr_u         addr,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [WORD_W-1:0]   rdata,
    // memory side
    output logic                rd_req,
    output logic [WORD_W-1:0]   rd_addr,
    input  logic                ret_valid,
    input  logic [LINE_W/2-1:0] ret_data,
    // register block
    input  cfg_t                cfg,
    output stat_t               stat,
    // tag store
    output logic [INDEX_W-1:0]  lookup_index,
    output logic [TAG_W-1:0]    lookup_tag,
    output tag_wr_t             tag_wr,
    output logic                touch,
    input  hit_info_t           hit,
    input  logic                victim,
    // data ram
    output logic [INDEX_W-1:0]  ram_rd_index,
    output logic                ram_rd_en,
    output logic [INDEX_W-1:0]  ram_wr_index,
    output logic                ram_wr_way,
    output logic                ram_wr_en,
    output logic [LINE_W/2-1:0] ram_wr_line,
    input  logic [LINE_W-1:0]   ram_rd_line
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        MISS   = 2'd2,
        REFILL = 2'd3
    } state_t;

    state_t state_q;
    state_t state_d;

    fetch_addr_u         req_q;
    logic [LINE_W/2-1:0] line_q;

    logic                accept;
    logic                lookup_hit;
    logic                fill;
    logic [LINE_W/2-1:0] hit_half;
    logic [WORD_W-1:0]   hit_word;
    logic [WORD_W-1:0]   refill_word;

    assign addr_ok = (state_q == IDLE);
    assign accept  = valid && addr_ok;

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= addr;
        end
    end

    // ram is read with the incoming index so data is ready in LOOKUP
    assign ram_rd_index = addr.fields.index;
    assign ram_rd_en    = accept;

    assign lookup_index = req_q.fields.index;
    assign lookup_tag   = req_q.fields.tag;

    // a disabled cache never hits
    assign lookup_hit = (state_q == LOOKUP) && hit.hit && cfg.enable;
    assign touch      = lookup_hit;

    assign stat.hit  = lookup_hit;
    assign stat.miss = (state_q == LOOKUP) && !lookup_hit;

    assign hit_half = hit.way ? ram_rd_line[LINE_W-1:LINE_W/2] : ram_rd_line[LINE_W/2-1:0];
    assign hit_word = hit_half[req_q.fields.word*WORD_W +: WORD_W];

    // memory request for the whole line
    assign rd_req  = (state_q == MISS);
    assign rd_addr = {req_q.fields.tag, req_q.fields.index, 3'b000};

    always_ff @(posedge clk) begin
        if (rd_req && ret_valid) begin
            line_q <= ret_data;
        end
    end

    assign refill_word = line_q[req_q.fields.word*WORD_W +: WORD_W];

    // no fill when disabled, and a fill racing a flush is dropped
    assign fill = (state_q == REFILL) && cfg.enable && !cfg.flush;

    assign tag_wr.we    = fill;
    assign tag_wr.way   = victim;
    assign tag_wr.index = req_q.fields.index;
    assign tag_wr.tag   = req_q.fields.tag;

    assign ram_wr_en    = fill;
    assign ram_wr_way   = victim;
    assign ram_wr_index = req_q.fields.index;
    assign ram_wr_line  = line_q;

    assign data_ok = lookup_hit || (state_q == REFILL);
    assign rdata   = (state_q == REFILL) ? refill_word : hit_word;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = lookup_hit ? IDLE : MISS;
            end
            MISS: begin
                if (ret_valid) begin
                    state_d = REFILL;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // data only follows an accept or a memory return by one cycle
    a_data_ok_state: assert property (
        @(posedge clk) disable iff (rst)
        data_ok |-> ($past(accept) || $past(rd_req && ret_valid))
    );

    // memory sees a steady request until it answers
    a_rd_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        (rd_req && !ret_valid) |=> (rd_req && $stable(rd_addr))
    );

endmodule

`default_nettype wire

//--- logic/icache_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module icache_cfg_regs import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [WORD_W-1:0]     cfg_wdata,
    output logic [WORD_W-1:0]     cfg_rdata,
    output cfg_t                  cfg,
    input  stat_t                 stat
);

    logic              enable_q;
    logic [WORD_W-1:0] hits_q;
    logic [WORD_W-1:0] misses_q;

    logic ctrl_we;
    logic cnt_clear;

    assign ctrl_we   = cfg_we && (cfg_addr == CFG_CTRL);
    assign cnt_clear = cfg_we && (cfg_addr == CFG_HITS || cfg_addr == CFG_MISSES);

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b1;
        end else if (ctrl_we) begin
            enable_q <= cfg_wdata[0];
        end
    end

    // flush lasts exactly the write cycle
    assign cfg.enable = enable_q;
    assign cfg.flush  = ctrl_we && cfg_wdata[1];

    // either counter address clears both
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            hits_q   <= '0;
            misses_q <= '0;
        end else begin
            hits_q   <= hits_q + WORD_W'(stat.hit);
            misses_q <= misses_q + WORD_W'(stat.miss);
        end
    end

    // flush bit always reads back as 0
    always_comb begin
        case (cfg_addr)
            CFG_CTRL:   cfg_rdata = {{(WORD_W-1){1'b0}}, enable_q};
            CFG_HITS:   cfg_rdata = hits_q;
            CFG_MISSES: cfg_rdata = misses_q;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // fetch port
    input  logic                  valid,
    input  logic [WORD_W-1:0]     addr,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [WORD_W-1:0]     rdata,
    // memory port
    output logic                  rd_req,
    output logic [WORD_W-1:0]     rd_addr,
    input  logic                  ret_valid,
    input  logic [LINE_W/2-1:0]   ret_data,
    // register port
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [WORD_W-1:0]     cfg_wdata,
    output logic [WORD_W-1:0]     cfg_rdata
);

    cfg_t                cfg;
    stat_t               stat;
    hit_info_t           hit;
    tag_wr_t             tag_wr;
    logic                touch;
    logic                victim;
    logic [INDEX_W-1:0]  lookup_index;
    logic [TAG_W-1:0]    lookup_tag;
    logic [INDEX_W-1:0]  ram_rd_index;
    logic                ram_rd_en;
    logic [INDEX_W-1:0]  ram_wr_index;
    logic                ram_wr_way;
    logic                ram_wr_en;
    logic [LINE_W/2-1:0] ram_wr_line;
    logic [LINE_W-1:0]   ram_rd_line;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .addr         (addr),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .cfg          (cfg),
        .stat         (stat),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .tag_wr       (tag_wr),
        .touch        (touch),
        .hit          (hit),
        .victim       (victim),
        .ram_rd_index (ram_rd_index),
        .ram_rd_en    (ram_rd_en),
        .ram_wr_index (ram_wr_index),
        .ram_wr_way   (ram_wr_way),
        .ram_wr_en    (ram_wr_en),
        .ram_wr_line  (ram_wr_line),
        .ram_rd_line  (ram_rd_line)
    );

    icache_tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .flush        (cfg.flush),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .tag_wr       (tag_wr),
        .touch        (touch),
        .hit          (hit),
        .victim       (victim)
    );

    icache_data_ram u_data_ram (
        .clk      (clk),
        .rd_index (ram_rd_index),
        .rd_en    (ram_rd_en),
        .wr_index (ram_wr_index),
        .wr_way   (ram_wr_way),
        .wr_en    (ram_wr_en),
        .wr_line  (ram_wr_line),
        .rd_line  (ram_rd_line)
    );

    icache_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg),
        .stat      (stat)
    );

endmodule

`default_nettype wire

//--- dv/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int MEM_LATENCY = 3;
    localparam int FETCH_LIMIT = 64;
    // about 1600 cycles of traffic in the slowest case, plus margin
    localparam int WATCHDOG_CYCLES = 2000;

    localparam logic [WORD_W-1:0] PATTERN = 32'h5a5a_0000;

    logic                  clk;
    logic                  rst;
    logic                  valid;
    logic [WORD_W-1:0]     addr;
    logic                  addr_ok;
    logic                  data_ok;
    logic [WORD_W-1:0]     rdata;
    logic                  rd_req;
    logic [WORD_W-1:0]     rd_addr;
    logic                  ret_valid;
    logic [LINE_W/2-1:0]   ret_data;
    logic                  cfg_we;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [WORD_W-1:0]     cfg_wdata;
    logic [WORD_W-1:0]     cfg_rdata;

    // reference model of the tag side
    logic             model_valid [2][SETS];
    logic [TAG_W-1:0] model_tag [2][SETS];
    logic             model_lru [SETS];
    logic             model_enable;
    int               model_hits;
    int               model_misses;

    int          mismatch_count;
    int          fail_count;
    logic [31:0] lfsr_state;

    icache_top DUT (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [WORD_W-1:0] expected_word(input logic [WORD_W-1:0] a);
        return {a[WORD_W-1:2], 2'b00} ^ PATTERN;
    endfunction

    // word 0 in the low half
    function automatic logic [LINE_W/2-1:0] line_data(input logic [WORD_W-1:0] line);
        return {(line + 32'd4) ^ PATTERN, line ^ PATTERN};
    endfunction

    function automatic fetch_addr_u make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_W-1:0] index,
                                              input logic word);
        fetch_addr_u a;
        a.fields.tag    = tag;
        a.fields.index  = index;
        a.fields.word   = word;
        a.fields.offset = 2'b00;
        return a;
    endfunction

    function automatic hit_info_t outcome(input logic h, input logic w);
        hit_info_t r;
        r.hit = h;
        r.way = w;
        return r;
    endfunction

    // galois form, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // predicts one lookup and applies its side effects
    function automatic hit_info_t model_access(input fetch_addr_u a);
        hit_info_t          r;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   t;
        logic               vict;
        idx = a.fields.index;
        t   = a.fields.tag;
        r   = '0;
        if (model_enable && model_valid[0][idx] && model_tag[0][idx] == t) begin
            r = outcome(1'b1, 1'b0);
        end else if (model_enable && model_valid[1][idx] && model_tag[1][idx] == t) begin
            r = outcome(1'b1, 1'b1);
        end
        if (r.hit) begin
            model_lru[idx] = ~r.way;
            model_hits++;
        end else begin
            model_misses++;
            if (model_enable) begin
                if (!model_valid[0][idx]) begin
                    vict = 1'b0;
                end else if (!model_valid[1][idx]) begin
                    vict = 1'b1;
                end else begin
                    vict = model_lru[idx];
                end
                model_tag[vict][idx]   = t;
                model_valid[vict][idx] = 1'b1;
                model_lru[idx]         = ~vict;
            end
        end
        return r;
    endfunction

    task automatic model_flush();
        int s;
        for (s = 0; s < SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_hit(input string name, input hit_info_t got, input hit_info_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got hit=%0b way=%0b expected hit=%0b way=%0b",
                     $time, name, got.hit, got.way, exp.hit, exp.way);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic reg_write(input logic [CFG_ADDR_W-1:0] a, input logic [WORD_W-1:0] d);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic reg_read(input logic [CFG_ADDR_W-1:0] a, output logic [WORD_W-1:0] d);
        cfg_addr = a;
        #2;
        d = cfg_rdata;
        @(posedge clk);
        #1;
    endtask

    // a hit is data_ok in the first cycle after accept
    task automatic fetch(input logic [WORD_W-1:0] a, output logic [WORD_W-1:0] word,
                         output hit_info_t got);
        int   waited;
        int   n;
        logic saw_req;
        logic done;
        got     = '0;
        word    = '0;
        waited  = 0;
        n       = 0;
        saw_req = 1'b0;
        done    = 1'b0;
        addr    = a;
        valid   = 1'b1;
        @(negedge clk);
        while (!addr_ok && waited < FETCH_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!addr_ok) begin
            fail_count++;
            $display("fetch of %h was never accepted", a);
            @(posedge clk);
            #1 valid = 1'b0;
            return;
        end
        @(posedge clk);
        #1 valid = 1'b0;
        while (!done) begin
            @(negedge clk);
            // busy from accept until the data returns
            check_flag("addr_ok", addr_ok, 1'b0);
            // no request in lookup, request right after a miss
            if (n == 0) begin
                check_flag("rd_req", rd_req, 1'b0);
            end else if (n == 1) begin
                check_flag("rd_req", rd_req, 1'b1);
            end
            if (rd_req && !saw_req) begin
                saw_req = 1'b1;
                check_word("rd_addr", rd_addr, {a[WORD_W-1:3], 3'b000});
            end
            if (data_ok) begin
                done = 1'b1;
                word = rdata;
                if (n == 0) begin
                    got = outcome(1'b1, DUT.hit.way);
                end else if (!saw_req) begin
                    fail_count++;
                    $display("fetch of %h finished late without a memory request", a);
                end
            end else if (n >= FETCH_LIMIT) begin
                done = 1'b1;
                fail_count++;
                $display("fetch of %h never returned data", a);
            end
            n++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic do_access(input fetch_addr_u a, output hit_info_t got);
        hit_info_t         exp;
        logic [WORD_W-1:0] word;
        exp = model_access(a);
        fetch(a.raw, word, got);
        check_word("rdata", word, expected_word(a.raw));
        check_hit("outcome", got, exp);
    endtask

    task automatic cold_miss_then_hit();
        hit_info_t got;
        do_access(make_addr(23'h000abc, 6'd3, 1'b0), got);
        check_hit("cold fetch", got, outcome(1'b0, 1'b0));
        do_access(make_addr(23'h000abc, 6'd3, 1'b1), got);
        check_hit("same line", got, outcome(1'b1, 1'b0));
    endtask

    task automatic two_way_conflict();
        hit_info_t got;
        do_access(make_addr(23'h001234, 6'd5, 1'b0), got);
        do_access(make_addr(23'h005678, 6'd5, 1'b0), got);
        do_access(make_addr(23'h001234, 6'd5, 1'b1), got);
        check_hit("touch a", got, outcome(1'b1, 1'b0));
        // b is the victim now
        do_access(make_addr(23'h019abc, 6'd5, 1'b0), got);
        check_hit("fill c", got, outcome(1'b0, 1'b0));
        do_access(make_addr(23'h001234, 6'd5, 1'b0), got);
        check_hit("a kept", got, outcome(1'b1, 1'b0));
        do_access(make_addr(23'h005678, 6'd5, 1'b1), got);
        check_hit("b evicted", got, outcome(1'b0, 1'b0));
    endtask

    task automatic flush_all();
        hit_info_t         got;
        logic [WORD_W-1:0] d;
        do_access(make_addr(23'h0000f1, 6'd20, 1'b0), got);
        do_access(make_addr(23'h0000f2, 6'd20, 1'b1), got);
        do_access(make_addr(23'h0000f1, 6'd20, 1'b1), got);
        check_hit("before flush t1", got, outcome(1'b1, 1'b0));
        do_access(make_addr(23'h0000f2, 6'd20, 1'b0), got);
        check_hit("before flush t2", got, outcome(1'b1, 1'b1));
        reg_write(CFG_CTRL, 32'h3);
        model_flush();
        reg_read(CFG_CTRL, d);
        check_reg("ctrl", d, 32'h1);
        do_access(make_addr(23'h0000f1, 6'd20, 1'b0), got);
        check_hit("after flush t1", got, outcome(1'b0, 1'b0));
        do_access(make_addr(23'h0000f2, 6'd20, 1'b1), got);
        check_hit("after flush t2", got, outcome(1'b0, 1'b0));
    endtask

    task automatic disabled_cache();
        hit_info_t got;
        int        i;
        reg_write(CFG_CTRL, 32'h0);
        model_enable = 1'b0;
        for (i = 0; i < 3; i++) begin
            do_access(make_addr(23'h03c0de, 6'd40, 1'b0), got);
            check_hit("disabled", got, outcome(1'b0, 1'b0));
        end
        reg_write(CFG_CTRL, 32'h1);
        model_enable = 1'b1;
        do_access(make_addr(23'h03c0de, 6'd40, 1'b0), got);
        check_hit("first after enable", got, outcome(1'b0, 1'b0));
        do_access(make_addr(23'h03c0de, 6'd40, 1'b1), got);
        check_hit("second after enable", got, outcome(1'b1, 1'b0));
    endtask

    task automatic random_traffic();
        hit_info_t          got;
        logic [TAG_W-1:0]   tags [4];
        logic [1:0]         sel;
        logic [INDEX_W-1:0] idx;
        logic               word;
        logic [WORD_W-1:0]  d;
        int                 i;
        tags[0] = 23'h000011;
        tags[1] = 23'h02a0a0;
        tags[2] = 23'h3c5001;
        tags[3] = 23'h7ff0f0;
        reg_write(CFG_HITS, 32'h0);
        model_hits   = 0;
        model_misses = 0;
        for (i = 0; i < 200; i++) begin
            sel  = 2'(random_bits(2));
            idx  = random_bits(1) ? 6'd11 : 6'd10;
            word = random_bits(1) != 0;
            do_access(make_addr(tags[sel], idx, word), got);
        end
        reg_read(CFG_HITS, d);
        check_reg("hits", d, WORD_W'(model_hits));
        reg_read(CFG_MISSES, d);
        check_reg("misses", d, WORD_W'(model_misses));
        // either counter address clears both
        reg_write(CFG_MISSES, 32'h0);
        reg_read(CFG_HITS, d);
        check_reg("hits cleared", d, 32'h0);
        reg_read(CFG_MISSES, d);
        check_reg("misses cleared", d, 32'h0);
    endtask

    // memory model
    initial begin
        logic [WORD_W-1:0] line;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                line = rd_addr;
                repeat (MEM_LATENCY) @(posedge clk);
                #1;
                ret_valid = 1'b1;
                ret_data  = line_data(line);
                @(posedge clk);
                #1;
                ret_valid = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        valid          = 1'b0;
        addr           = '0;
        cfg_we         = 1'b0;
        cfg_addr       = '0;
        cfg_wdata      = '0;
        lfsr_state     = 32'heef6;
        mismatch_count = 0;
        fail_count     = 0;
        model_enable   = 1'b1;
        model_hits     = 0;
        model_misses   = 0;
        model_flush();
        for (int s = 0; s < SETS; s++) begin
            model_lru[s] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        cold_miss_then_hit();
        two_way_conflict();
        flush_all();
        disabled_cache();
        random_traffic();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_ram.sv
logic/icache_ctrl.sv
logic/icache_cfg_regs.sv
logic/icache_top.sv
dv/icache_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = icache_tb
FILELIST = all.f

BUILD    = obj_dir
LOG      = sim.log
PASS     = Test OK
SOURCES  = $(wildcard logic/*.sv) $(wildcard dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
